//--- rtl/frame_consts.svh
`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

// package header byte, same on all four packages
`define FRAME_HDR_BYTE 8'h55
// function byte of the first package, marks frame start
`define FRAME_FUNC_BYTE 8'h50

// frame layout
`define PKG_SIZE 11
`define PKG_NUM 4
`define FRAME_BYTES (`PKG_SIZE * `PKG_NUM)
`define PAYLOAD_PER_PKG 8
`define PAYLOAD_BYTES (`PAYLOAD_PER_PKG * `PKG_NUM)

// package with ax, ay, az, temp
`define ACCEL_PKG 1

// resting magnitude squared, 1 g at full scale
`define ENERGY_G 32'h0040_0000
// band half width around G
`define ENERGY_T 32'h0010_0000

`endif

//--- rtl/frame_pkg.sv
`default_nettype none
`include "frame_consts.svh"

package frame_pkg;

	// one signed acceleration sample
	typedef logic signed [15:0] axis_t;

	// one package payload, 8 bytes
	// byte view for assembly, axis view for decode
	typedef union packed {
		logic [`PAYLOAD_PER_PKG-1:0][7:0] bytes;
		struct packed {
			axis_t temp;
			axis_t az;
			axis_t ay;
			// bytes 1:0, low byte first on the wire
			axis_t ax;
		} axes;
	} accel_word_u;

	// all payload bytes, slot n at bits 8n+7:8n
	typedef logic [`PAYLOAD_BYTES*8-1:0] record_t;

	// payload slot 0..31
	typedef logic [4:0] slot_t;

endpackage

`default_nettype wire

//--- rtl/accel_if.sv
`default_nettype none

interface accel_if
	import frame_pkg::*;
();

	// decoded axes, held until the next frame
	axis_t ax;
	axis_t ay;
	axis_t az;
	// one pulse per completed frame
	logic accel_valid;

	// collector side
	modport src (output ax, output ay, output az, output accel_valid);
	// detector side
	modport dst (input ax, input ay, input az, input accel_valid);

endinterface

`default_nettype wire

//--- rtl/frame_sync.sv
`default_nettype none
`include "frame_consts.svh"

module frame_sync
	import frame_pkg::*;
(
	input wire clk_50m,
	input wire sys_rst_n,
	input wire [7:0] rx_data_i,
	input wire rx_valid_i,
	output logic [7:0] pay_data_o,
	output logic pay_valid_o,
	output slot_t pay_slot_o
);

	localparam logic [1:0] ST_HUNT = 2'd0;
	localparam logic [1:0] ST_FUNC = 2'd1;
	localparam logic [1:0] ST_LOCK = 2'd2;

	// payload sits at offsets 2..9 inside each package
	localparam int PAY_FIRST = 2;
	localparam int PAY_LAST = PAY_FIRST + `PAYLOAD_PER_PKG - 1;

	logic [1:0] state;
	// byte position inside the frame, 2..43 while locked
	logic [5:0] pos;
	// offset inside the current package
	logic [3:0] byte_off;
	logic [$clog2(`PKG_NUM)-1:0] pkg_idx;
	logic is_payload;
	logic frame_end;
	slot_t slot_cur;

	assign is_payload = (byte_off >= PAY_FIRST) && (byte_off <= PAY_LAST);
	assign frame_end = (pos == 6'(`FRAME_BYTES - 1));
	// 8 slots per package, offset 2 maps to slot 0
	assign slot_cur = slot_t'(pkg_idx * `PAYLOAD_PER_PKG + byte_off - PAY_FIRST);

	always_ff @(posedge clk_50m)
		begin
		if (!sys_rst_n)
			begin
			state <= ST_HUNT;
			pos <= '0;
			byte_off <= '0;
			pkg_idx <= '0;
			end
		else if (rx_valid_i)
			begin
			case (state)
				ST_HUNT:
					begin
					if (rx_data_i == `FRAME_HDR_BYTE)
						state <= ST_FUNC;
					end
				ST_FUNC:
					begin
					// header and function already seen, next byte is position 2
					if (rx_data_i == `FRAME_FUNC_BYTE)
						begin
						state <= ST_LOCK;
						pos <= 6'd2;
						byte_off <= 4'd2;
						pkg_idx <= '0;
						end
					else
						state <= ST_HUNT;
					end
				ST_LOCK:
					begin
					// checksum of package 3 closes the frame
					if (frame_end)
						state <= ST_HUNT;
					pos <= pos + 6'd1;
					if (byte_off == 4'(`PKG_SIZE - 1))
						begin
						byte_off <= '0;
						pkg_idx <= pkg_idx + 1'b1;
						end
					else
						byte_off <= byte_off + 4'd1;
					end
				default:
					state <= ST_HUNT;
			endcase
			end
		end

	// header, function and checksum bytes dropped here
	always_ff @(posedge clk_50m)
		begin
		if (!sys_rst_n)
			pay_valid_o <= 1'b0;
		else
			pay_valid_o <= rx_valid_i && (state == ST_LOCK) && is_payload;
		end

	always_ff @(posedge clk_50m)
		begin
		if (rx_valid_i)
			begin
			pay_data_o <= rx_data_i;
			pay_slot_o <= slot_cur;
			end
		end

endmodule

`default_nettype wire

//--- rtl/payload_collector.sv
`default_nettype none
`include "frame_consts.svh"

module payload_collector
	import frame_pkg::*;
(
	input wire clk_50m,
	input wire sys_rst_n,
	input wire [7:0] pay_data_i,
	input wire pay_valid_i,
	input wire slot_t pay_slot_i,
	output record_t record_o,
	accel_if.src accel
);

	localparam slot_t LAST_SLOT = slot_t'(`PAYLOAD_BYTES - 1);

	// record under assembly, overwritten slot by slot each frame
	record_t work;
	record_t work_next;
	logic last_byte;
	logic accel_valid_q;
	accel_word_u accel_word;

	// current byte merged in, so slot 31 reaches record_o on the same edge
	always_comb
		begin
		work_next = work;
		work_next[pay_slot_i * 8 +: 8] = pay_data_i;
		end

	assign last_byte = pay_valid_i && (pay_slot_i == LAST_SLOT);

	always_ff @(posedge clk_50m)
		begin
		if (pay_valid_i)
			work <= work_next;
		end

	// record_o holds until the next frame completes
	always_ff @(posedge clk_50m)
		begin
		if (!sys_rst_n)
			begin
			record_o <= '0;
			accel_valid_q <= 1'b0;
			end
		else
			begin
			accel_valid_q <= last_byte;
			if (last_byte)
				record_o <= work_next;
			end
		end

	// gather the acceleration package byte by byte
	always_comb
		begin
		for (int i = 0; i < `PAYLOAD_PER_PKG; i++)
			accel_word.bytes[i] = record_o[(`ACCEL_PKG * `PAYLOAD_PER_PKG + i) * 8 +: 8];
		end

	// then read it back as signed axes, temp unused downstream
	assign accel.ax = accel_word.axes.ax;
	assign accel.ay = accel_word.axes.ay;
	assign accel.az = accel_word.axes.az;
	assign accel.accel_valid = accel_valid_q;

endmodule

`default_nettype wire

//--- rtl/energy_detector.sv
`default_nettype none
`include "frame_consts.svh"

module energy_detector
	import frame_pkg::*;
(
	input wire clk_50m,
	input wire sys_rst_n,
	accel_if.dst accel,
	output logic energy_o,
	output logic record_valid_o
);

	// both band edges count as energetic
	localparam logic [31:0] BAND_HI = `ENERGY_G + `ENERGY_T;
	localparam logic [31:0] BAND_LO = `ENERGY_G - `ENERGY_T;

	logic [31:0] sq_x;
	logic [31:0] sq_y;
	logic [31:0] sq_z;
	logic [31:0] sum_xyz;
	logic energetic;

	// two's complement magnitude squared
	// 0x8000 gives 0x8000 as unsigned magnitude
	function automatic logic [31:0] mag_sq(input axis_t v);
		logic [15:0] mag;
		mag = v[15] ? (~v + 16'd1) : v;
		return 32'(mag) * 32'(mag);
	endfunction

	assign sq_x = mag_sq(accel.ax);
	assign sq_y = mag_sq(accel.ay);
	assign sq_z = mag_sq(accel.az);

	// each square at most 2^30, so three of them never carry out of 32 bits
	assign sum_xyz = sq_x + sq_y + sq_z;

	assign energetic = (sum_xyz >= BAND_HI)
		|| (sum_xyz <= BAND_LO);

	// flag holds its value between frames
	always_ff @(posedge clk_50m)
		begin
		if (!sys_rst_n)
			begin
			energy_o <= 1'b0;
			record_valid_o <= 1'b0;
			end
		else
			begin
			record_valid_o <= accel.accel_valid;
			if (accel.accel_valid)
				energy_o <= energetic;
			end
		end

endmodule

`default_nettype wire

//--- rtl/motion_frame_top.sv
`default_nettype none
`include "frame_consts.svh"

module motion_frame_top
	import frame_pkg::*;
(
	input wire clk_50m,
	input wire sys_rst_n,
	input wire [7:0] rx_data_i,
	input wire rx_valid_i,
	output wire [`PAYLOAD_BYTES*8-1:0] record_o,
	output wire energy_o,
	output wire record_valid_o
);

	// stripped payload stream
	logic [7:0] pay_data;
	logic pay_valid;
	slot_t pay_slot;

	// decoded axes from collector to detector
	accel_if accel_bus ();

	// byte stream in, payload bytes with slot numbers out
	frame_sync u_frame_sync (
		.clk_50m		(clk_50m),
		.sys_rst_n		(sys_rst_n),
		.rx_data_i		(rx_data_i),
		.rx_valid_i		(rx_valid_i),
		.pay_data_o		(pay_data),
		.pay_valid_o	(pay_valid),
		.pay_slot_o		(pay_slot)
	);

	// record assembly and axis decode
	payload_collector u_payload_collector (
		.clk_50m		(clk_50m),
		.sys_rst_n		(sys_rst_n),
		.pay_data_i		(pay_data),
		.pay_valid_i	(pay_valid),
		.pay_slot_i		(pay_slot),
		.record_o		(record_o),
		.accel			(accel_bus.src)
	);

	// squared magnitude against the quiet band
	energy_detector u_energy_detector (
		.clk_50m		(clk_50m),
		.sys_rst_n		(sys_rst_n),
		.accel			(accel_bus.dst),
		.energy_o		(energy_o),
		.record_valid_o	(record_valid_o)
	);

endmodule

`default_nettype wire

//--- tests/motion_frame_props.sv
`default_nettype none

module motion_frame_props (
	input wire clk_50m,
	input wire sys_rst_n,
	input wire rx_valid_i,
	input wire energy_o,
	input wire record_valid_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// one pulse per frame, never stretched
	assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		record_valid_o |=> !record_valid_o)
	else
		$error("record_valid_o high on two consecutive cycles");

	// sync reset clears both flags on the following edge
	assert property (@(posedge clk_50m)
		!sys_rst_n |=> (!record_valid_o && !energy_o))
	else
		$error("record_valid_o or energy_o high during reset");

	// last payload byte passes sync, collector and detector stages
	assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		record_valid_o |-> $past(rx_valid_i, 3))
	else
		$error("record_valid_o without an rx strobe three cycles earlier");

endmodule

bind motion_frame_top motion_frame_props u_props (
	.clk_50m		(clk_50m),
	.sys_rst_n		(sys_rst_n),
	.rx_valid_i		(rx_valid_i),
	.energy_o		(energy_o),
	.record_valid_o	(record_valid_o)
);

`default_nettype wire

//--- tests/motion_frame_tb.sv
`default_nettype none
`include "frame_consts.svh"

module motion_frame_tb
	import frame_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic clk_50m;
	logic sys_rst_n;
	logic [7:0] rx_data_i;
	logic rx_valid_i;
	record_t record_o;
	logic energy_o;
	logic record_valid_o;

	integer seed;
	int check_cnt;
	int mismatch_cnt;
	int fail_cnt;
	// frame under construction, header first
	logic [7:0] frame_buf [0:`FRAME_BYTES-1];
	// expectations in frame order
	record_t exp_rec_q [$];
	logic exp_nrg_q [$];
	record_t exp_rec;
	logic exp_nrg;

	motion_frame_top UUT (
		.clk_50m		(clk_50m),
		.sys_rst_n		(sys_rst_n),
		.rx_data_i		(rx_data_i),
		.rx_valid_i		(rx_valid_i),
		.record_o		(record_o),
		.energy_o		(energy_o),
		.record_valid_o	(record_valid_o)
	);

	initial
		begin
		clk_50m = 1'b0;
		forever #10 clk_50m = ~clk_50m;
		end

	// magnitude squared, wide enough for any sum of three
	function automatic longint sq_mag(input axis_t v);
		longint m;
		m = v;
		if (m < 0)
			m = -m;
		return m * m;
	endfunction

	// payload slots in wire order, axes from package 1, low byte first
	function automatic void ref_frame(input logic [7:0] fr [0:`FRAME_BYTES-1],
		output record_t rec, output logic nrg);
		int base;
		longint sum;
		rec = '0;
		for (int p = 0; p < `PKG_NUM; p++)
			for (int k = 0; k < `PAYLOAD_PER_PKG; k++)
				rec[(p * `PAYLOAD_PER_PKG + k) * 8 +: 8] = fr[p * `PKG_SIZE + 2 + k];
		base = `ACCEL_PKG * `PKG_SIZE + 2;
		sum = sq_mag({fr[base + 1], fr[base]}) + sq_mag({fr[base + 3], fr[base + 2]})
			+ sq_mag({fr[base + 5], fr[base + 4]});
		nrg = (sum > 64'hFFFF_FFFF) || (sum >= `ENERGY_G + `ENERGY_T)
			|| (sum <= `ENERGY_G - `ENERGY_T);
	endfunction

	// random bytes, then header and function byte on every package
	task automatic build_frame();
		for (int i = 0; i < `FRAME_BYTES; i++)
			frame_buf[i] = 8'($random(seed));
		for (int p = 0; p < `PKG_NUM; p++)
			begin
			frame_buf[p * `PKG_SIZE] = `FRAME_HDR_BYTE;
			frame_buf[p * `PKG_SIZE + 1] = `FRAME_FUNC_BYTE + 8'(p);
			end
	endtask

	task automatic set_axes(input axis_t ax, input axis_t ay, input axis_t az);
		int base;
		base = `ACCEL_PKG * `PKG_SIZE + 2;
		frame_buf[base] = ax[7:0];
		frame_buf[base + 1] = ax[15:8];
		frame_buf[base + 2] = ay[7:0];
		frame_buf[base + 3] = ay[15:8];
		frame_buf[base + 4] = az[7:0];
		frame_buf[base + 5] = az[15:8];
	endtask

	// one strobe per byte, up to max_gap idle cycles after each
	task automatic send_frame(input int max_gap, input bit expect_rec);
		record_t rec;
		logic nrg;
		int gap;
		if (expect_rec)
			begin
			ref_frame(frame_buf, rec, nrg);
			exp_rec_q.push_back(rec);
			exp_nrg_q.push_back(nrg);
			end
		for (int i = 0; i < `FRAME_BYTES; i++)
			begin
			rx_data_i = frame_buf[i];
			rx_valid_i = 1'b1;
			@(negedge clk_50m);
			rx_valid_i = 1'b0;
			gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
			repeat (gap)
				@(negedge clk_50m);
			end
	endtask

	// queue only changes on negedge, so poll on posedge
	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_rec_q.size() != 0 && n < limit)
			begin
			@(posedge clk_50m);
			n++;
			end
		if (exp_rec_q.size() != 0)
			begin
			fail_cnt++;
			$display("timeout waiting for record_valid_o, %0d frames lost", exp_rec_q.size());
			exp_rec_q.delete();
			exp_nrg_q.delete();
			end
		@(negedge clk_50m);
	endtask

	task automatic run_axes(input axis_t ax, input axis_t ay, input axis_t az);
		build_frame();
		set_axes(ax, ay, az);
		send_frame(1, 1'b1);
		wait_drain(200);
	endtask

	// body bytes below 0x40, so no 0x55 can relock the sync
	task automatic send_bad(input logic [7:0] hdr, input logic [7:0] func);
		for (int i = 2; i < `FRAME_BYTES; i++)
			frame_buf[i] = 8'($random(seed)) & 8'h3f;
		frame_buf[0] = hdr;
		frame_buf[1] = func;
		send_frame(0, 1'b0);
		// quiet window, any pulse is caught by the comparer
		repeat (60)
			@(negedge clk_50m);
	endtask

	// outputs settle after posedge, sampled half a cycle later
	always @(negedge clk_50m)
		begin
		if (sys_rst_n && record_valid_o)
			begin
			if (exp_rec_q.size() == 0)
				begin
				fail_cnt++;
				$display("record_valid_o pulsed with no frame expected at %0t", $time);
				end
			else
				begin
				exp_rec = exp_rec_q.pop_front();
				exp_nrg = exp_nrg_q.pop_front();
				check_cnt++;
				assert (record_o == exp_rec)
				else
					begin
					mismatch_cnt++;
					$display("mismatch record_o: got %h expected %h", record_o, exp_rec);
					end
				assert (energy_o == exp_nrg)
				else
					begin
					mismatch_cnt++;
					$display("mismatch energy_o: got %h expected %h", energy_o, exp_nrg);
					end
				end
			end
		end

	initial
		begin
		seed = 32'hde3a_8c21;
		check_cnt = 0;
		mismatch_cnt = 0;
		fail_cnt = 0;
		sys_rst_n = 1'b0;
		rx_data_i = 8'h00;
		rx_valid_i = 1'b0;
		repeat (5)
			@(posedge clk_50m);
		@(negedge clk_50m);
		assert (!record_valid_o && !energy_o && record_o == '0)
		else
			begin
			mismatch_cnt++;
			$display("mismatch after reset: record_valid_o %h energy_o %h record_o %h",
				record_valid_o, energy_o, record_o);
			end
		sys_rst_n = 1'b1;
		// idle line, no pulse expected
		repeat (20)
			@(negedge clk_50m);

		// back to back, then with gaps
		for (int f = 0; f < 6; f++)
			begin
			build_frame();
			send_frame(0, 1'b1);
			end
		wait_drain(200);
		for (int f = 0; f < 6; f++)
			begin
			build_frame();
			send_frame(3, 1'b1);
			end
		wait_drain(200);

		// rest, band edges, just inside the edges, largest sums
		run_axes(16'sh0800, 16'sh0000, 16'sh0000);
		run_axes(16'sh0800, 16'sh0400, 16'sh0000);
		run_axes(16'sh0400, 16'sh0400, 16'sh0400);
		run_axes(16'sh0800, 16'sh03ff, 16'sh0000);
		run_axes(16'sh0400, 16'sh0400, 16'sh0401);
		run_axes(16'sh7fff, 16'sh7fff, 16'sh7fff);
		run_axes(-16'sh8000, -16'sh8000, -16'sh8000);
		// negative twins of the cases above
		run_axes(-16'sh0800, 16'sh0000, 16'sh0000);
		run_axes(-16'sh0800, -16'sh0400, 16'sh0000);
		run_axes(-16'sh0400, 16'sh0400, -16'sh0401);

		// bad header, then bad function bytes
		send_bad(8'haa, `FRAME_FUNC_BYTE);
		send_bad(`FRAME_HDR_BYTE, 8'h51);
		send_bad(`FRAME_HDR_BYTE, 8'h00);
		run_axes(16'sh0123, -16'sh0456, 16'sh0789);

		$display("checks %0d, mismatches %0d, other errors %0d",
			check_cnt, mismatch_cnt, fail_cnt);
		if (mismatch_cnt + fail_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
		end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/frame_pkg.sv
rtl/accel_if.sv
rtl/frame_sync.sv
rtl/payload_collector.sv
rtl/energy_detector.sv
rtl/motion_frame_top.sv
tests/motion_frame_props.sv
tests/motion_frame_tb.sv

//--- Makefile
TOP := motion_frame_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
